// ==== logic/nvram_consts.svh ====
`ifndef NVRAM_CONSTS_SVH
`define NVRAM_CONSTS_SVH

// Number of mounted image channels
`define NVRAM_CHANNELS 4
`define NVRAM_CHAN_W 2

// 512-byte SD blocks
`define NVRAM_BLOCK_SHIFT 9

`define NVRAM_LBA_W 32
`define NVRAM_COUNT_W 13 // Block count and RAM block index
`define NVRAM_RAM_W 25 // RAM byte offset
`define NVRAM_SIZE_W 64 // Image size in bytes

`endif

// ==== logic/nvram_pkg.sv ====
`include "nvram_consts.svh"

package nvram_pkg;

   typedef enum logic {
      OP_LOAD = 1'b0,
      OP_SAVE = 1'b1
   } nvram_op_t;

   // One channel's area in the image and in RAM
   typedef struct packed {
      logic [`NVRAM_LBA_W-1:0]   lba_start;
      logic [`NVRAM_COUNT_W-1:0] block_count;
      logic [`NVRAM_RAM_W-1:0]   ram_offset;
   } nvram_region_t;

   typedef struct packed {
      logic [`NVRAM_CHAN_W-1:0] channel;
      nvram_op_t                op;
      nvram_region_t            region;
   } nvram_job_t;

   // Size update after format extension
   typedef struct packed {
      logic                      valid;
      logic [`NVRAM_CHAN_W-1:0]  channel;
      logic [`NVRAM_SIZE_W-1:0]  new_size;
   } nvram_grow_t;

   typedef struct packed {
      logic [`NVRAM_CHAN_W-1:0]  channel;
      nvram_op_t                 op;
      logic [`NVRAM_COUNT_W-1:0] fmt_blocks;
      logic [`NVRAM_COUNT_W-1:0] xfer_blocks;
      logic [`NVRAM_SIZE_W-1:0]  final_size;
   } nvram_report_t;

endpackage

// ==== logic/nvram_request_arbiter.sv ====
`timescale 1ns/10ps
`include "nvram_consts.svh"

module nvram_request_arbiter
   import nvram_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic [`NVRAM_CHANNELS-1:0] load_req,
   input  logic [`NVRAM_CHANNELS-1:0] save_req,
   input  nvram_region_t              regions [`NVRAM_CHANNELS],
   input  logic                       busy,
   output nvram_job_t                 job,
   output logic                       job_valid,
   output logic                       pending
);

   logic [`NVRAM_CHANNELS-1:0] pend_load;
   logic [`NVRAM_CHANNELS-1:0] pend_save;
   logic [`NVRAM_CHANNELS-1:0] ptr_sel;
   logic [`NVRAM_CHANNELS-1:0] clr_load;
   logic [`NVRAM_CHANNELS-1:0] clr_save;
   logic [`NVRAM_CHAN_W-1:0]   ptr;
   logic                       hit;
   logic                       can_issue;

   assign ptr_sel = `NVRAM_CHANNELS'(1) << ptr;
   assign hit = pend_save[ptr] | pend_load[ptr];

   // Wait one cycle after an issue so busy has time to rise
   assign can_issue = ~busy & ~job_valid & hit;

   // Save wins over load on the same channel
   assign clr_save = (can_issue & pend_save[ptr]) ? ptr_sel : '0;
   assign clr_load = (can_issue & ~pend_save[ptr]) ? ptr_sel : '0;

   assign pending = |(pend_load | pend_save);

   always_ff @(posedge clk) begin
      if (reset) begin
         pend_load <= '0;
         pend_save <= '0;
         ptr       <= '0;
         job_valid <= 1'b0;
      end else begin
         // New strobes merge into the pending sets
         pend_load <= (pend_load & ~clr_load) | load_req;
         pend_save <= (pend_save & ~clr_save) | save_req;
         job_valid <= can_issue;
         if (can_issue | ~hit)
            ptr <= ptr + 1'b1; // Next channel in turn
      end
   end

   always_ff @(posedge clk) begin
      if (can_issue) begin
         job.channel <= ptr;
         job.op      <= pend_save[ptr] ? OP_SAVE : OP_LOAD;
         job.region  <= regions[ptr];
      end
   end

   a_issue_idle: assert property (@(posedge clk) disable iff (reset)
      $rose(job_valid) |-> !busy);

endmodule

// ==== logic/nvram_transfer_fsm.sv ====
`timescale 1ns/10ps
`include "nvram_consts.svh"

module nvram_transfer_fsm
   import nvram_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  nvram_job_t                 job,
   input  logic                       job_valid,
   input  logic [`NVRAM_SIZE_W-1:0]   cur_size,
   output logic [`NVRAM_CHAN_W-1:0]   job_channel,
   output logic                       busy,
   output logic [`NVRAM_CHANNELS-1:0] sd_rd,
   output logic [`NVRAM_CHANNELS-1:0] sd_wr,
   output logic [`NVRAM_LBA_W-1:0]    sd_lba,
   input  logic [`NVRAM_CHANNELS-1:0] sd_ack,
   output logic [`NVRAM_COUNT_W-1:0]  ram_lba,
   output logic [`NVRAM_RAM_W-1:0]    ram_offset,
   output logic                       ram_we,
   output logic                       ram_format,
   output nvram_grow_t                grow,
   output logic                       finish,
   output logic [`NVRAM_COUNT_W-1:0]  fmt_count,
   output logic [`NVRAM_COUNT_W-1:0]  xfer_count
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CHECK,
      ST_FORMAT,
      ST_PROCESS,
      ST_FINISH
   } state_t;

   state_t                     state;
   nvram_job_t                 job_q;
   logic [`NVRAM_LBA_W-1:0]    fmt_base; // First LBA past the old image end
   logic [`NVRAM_COUNT_W-1:0]  fmt_total;
   logic [`NVRAM_CHANNELS-1:0] chan_sel;
   logic [`NVRAM_SIZE_W-1:0]   region_end;
   logic [`NVRAM_SIZE_W-1:0]   size_blocks;
   logic [`NVRAM_SIZE_W-1:0]   ext_blocks;
   logic                       ack_q;
   logic                       ack_fall;

   assign job_channel = job_q.channel;
   assign chan_sel = `NVRAM_CHANNELS'(1) << job_q.channel;

   assign region_end = `NVRAM_SIZE_W'(job_q.region.lba_start) +
                       `NVRAM_SIZE_W'(job_q.region.block_count);
   assign size_blocks = cur_size >> `NVRAM_BLOCK_SHIFT;
   assign ext_blocks = region_end - size_blocks;

   assign ack_fall = ack_q & ~sd_ack[job_q.channel];

   // Requests are held for the whole state, one channel at a time
   assign busy = (state != ST_IDLE);
   assign ram_format = (state == ST_FORMAT);
   assign sd_rd = (state == ST_PROCESS && job_q.op == OP_LOAD) ? chan_sel : '0;
   assign sd_wr = (ram_format || (state == ST_PROCESS && job_q.op == OP_SAVE)) ?
                  chan_sel : '0;
   assign ram_we = |sd_rd;

   assign ram_lba = ram_format ? fmt_count : xfer_count;
   assign ram_offset = job_q.region.ram_offset;
   assign sd_lba = (ram_format ? fmt_base : job_q.region.lba_start) +
                   `NVRAM_LBA_W'(ram_lba);

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ST_IDLE;
         ack_q      <= 1'b0;
         finish     <= 1'b0;
         grow.valid <= 1'b0;
         fmt_count  <= '0;
         xfer_count <= '0;
      end else begin
         ack_q      <= sd_ack[job_q.channel];
         finish     <= 1'b0;
         grow.valid <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (job_valid) begin
                  fmt_count  <= '0;
                  xfer_count <= '0;
                  state      <= ST_CHECK;
               end
            end
            ST_CHECK: begin
               if (job_q.region.block_count == '0) begin
                  finish <= 1'b1; // Nothing to move
                  state  <= ST_IDLE;
               end else if (region_end > size_blocks) begin
                  state <= ST_FORMAT;
               end else begin
                  state <= ST_PROCESS;
               end
            end
            ST_FORMAT: begin
               if (ack_fall) begin
                  fmt_count <= fmt_count + 1'b1;
                  if (fmt_count == fmt_total - 1'b1) begin
                     grow.valid <= 1'b1;
                     state      <= ST_PROCESS;
                  end
               end
            end
            ST_PROCESS: begin
               if (ack_fall) begin
                  xfer_count <= xfer_count + 1'b1;
                  if (xfer_count == job_q.region.block_count - 1'b1)
                     state <= ST_FINISH;
               end
            end
            ST_FINISH: begin
               finish <= 1'b1;
               state  <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && job_valid)
         job_q <= job;
      if (state == ST_CHECK) begin
         fmt_base  <= size_blocks[`NVRAM_LBA_W-1:0];
         fmt_total <= ext_blocks[`NVRAM_COUNT_W-1:0];
      end
      grow.channel  <= job_q.channel;
      grow.new_size <= cur_size +
                       (`NVRAM_SIZE_W'(fmt_total) << `NVRAM_BLOCK_SHIFT);
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
      !(|sd_rd && |sd_wr));

   a_one_channel: assert property (@(posedge clk) disable iff (reset)
      $onehot0(sd_rd | sd_wr));

   a_format_is_write: assert property (@(posedge clk) disable iff (reset)
      ram_format |-> |sd_wr);

endmodule

// ==== logic/nvram_completion.sv ====
`timescale 1ns/10ps
`include "nvram_consts.svh"

module nvram_completion
   import nvram_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic [`NVRAM_CHANNELS-1:0] img_mounted,
   input  logic [`NVRAM_SIZE_W-1:0]   img_size,
   input  nvram_grow_t                grow,
   input  logic [`NVRAM_CHAN_W-1:0]   job_channel,
   output logic [`NVRAM_SIZE_W-1:0]   cur_size,
   input  logic                       finish,
   input  logic [`NVRAM_COUNT_W-1:0]  fmt_count,
   input  logic [`NVRAM_COUNT_W-1:0]  xfer_count,
   input  nvram_job_t                 job,
   output nvram_report_t              report,
   output logic                       done
);

   logic [`NVRAM_SIZE_W-1:0] size_tab [`NVRAM_CHANNELS];

   assign cur_size = size_tab[job_channel];

   // Mount overrides a grow for the same channel
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NVRAM_CHANNELS; i++)
            size_tab[i] <= '0;
      end else begin
         for (int i = 0; i < `NVRAM_CHANNELS; i++) begin
            if (img_mounted[i])
               size_tab[i] <= img_size;
            else if (grow.valid && grow.channel == i)
               size_tab[i] <= grow.new_size;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         done <= 1'b0;
      else
         done <= finish;
   end

   always_ff @(posedge clk) begin
      if (finish) begin
         report.channel     <= job.channel;
         report.op          <= job.op;
         report.fmt_blocks  <= fmt_count;
         report.xfer_blocks <= xfer_count;
         report.final_size  <= cur_size; // Already includes any growth
      end
   end

   // Grow always belongs to the job in flight
   a_grow_channel: assert property (@(posedge clk) disable iff (reset)
      grow.valid |-> (grow.channel == job_channel && job.channel == job_channel));

endmodule

// ==== logic/nvram_sync.sv ====
`timescale 1ns/10ps
`include "nvram_consts.svh"

module nvram_sync
   import nvram_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  nvram_region_t              regions [`NVRAM_CHANNELS],
   input  logic [`NVRAM_CHANNELS-1:0] img_mounted,
   input  logic [`NVRAM_SIZE_W-1:0]   img_size,
   input  logic [`NVRAM_CHANNELS-1:0] load_req,
   input  logic [`NVRAM_CHANNELS-1:0] save_req,
   output logic                       ready,
   output logic [`NVRAM_CHANNELS-1:0] sd_rd,
   output logic [`NVRAM_CHANNELS-1:0] sd_wr,
   output logic [`NVRAM_LBA_W-1:0]    sd_lba,
   input  logic [`NVRAM_CHANNELS-1:0] sd_ack,
   output logic [`NVRAM_COUNT_W-1:0]  ram_lba,
   output logic [`NVRAM_RAM_W-1:0]    ram_offset,
   output logic                       ram_we,
   output logic                       ram_format,
   output nvram_report_t              report,
   output logic                       done
);

   nvram_job_t                job;
   nvram_grow_t               grow;
   logic                      job_valid;
   logic                      busy;
   logic                      pending;
   logic                      finish;
   logic [`NVRAM_CHAN_W-1:0]  job_channel;
   logic [`NVRAM_SIZE_W-1:0]  cur_size;
   logic [`NVRAM_COUNT_W-1:0] fmt_count;
   logic [`NVRAM_COUNT_W-1:0] xfer_count;

   // An issued job counts as work until busy rises
   assign ready = ~pending & ~busy & ~job_valid;

   nvram_request_arbiter u_arbiter (
      .clk       (clk),
      .reset     (reset),
      .load_req  (load_req),
      .save_req  (save_req),
      .regions   (regions),
      .busy      (busy),
      .job       (job),
      .job_valid (job_valid),
      .pending   (pending)
   );

   nvram_transfer_fsm u_transfer (
      .clk         (clk),
      .reset       (reset),
      .job         (job),
      .job_valid   (job_valid),
      .cur_size    (cur_size),
      .job_channel (job_channel),
      .busy        (busy),
      .sd_rd       (sd_rd),
      .sd_wr       (sd_wr),
      .sd_lba      (sd_lba),
      .sd_ack      (sd_ack),
      .ram_lba     (ram_lba),
      .ram_offset  (ram_offset),
      .ram_we      (ram_we),
      .ram_format  (ram_format),
      .grow        (grow),
      .finish      (finish),
      .fmt_count   (fmt_count),
      .xfer_count  (xfer_count)
   );

   nvram_completion u_completion (
      .clk         (clk),
      .reset       (reset),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .grow        (grow),
      .job_channel (job_channel),
      .cur_size    (cur_size),
      .finish      (finish),
      .fmt_count   (fmt_count),
      .xfer_count  (xfer_count),
      .job         (job),
      .report      (report),
      .done        (done)
   );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

// Free-running clock, starts low
module tb_clock #(
   parameter int PERIOD_NS = 100
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

// ==== tests/nvram_sync_tb.sv ====
`timescale 1ns/10ps
`include "nvram_consts.svh"

module nvram_sync_tb
   import nvram_pkg::*;
();

   localparam logic [31:0] SEED = 32'h7bf0_f7b2;
   localparam int TIMEOUT = 2000; // Cycles per wait

   // One block as the card saw it at the rising ack
   typedef struct packed {
      logic [`NVRAM_CHAN_W-1:0]  channel;
      logic [`NVRAM_LBA_W-1:0]   lba;
      logic                      rd;
      logic                      wr;
      logic                      fmt;
      logic                      we;
      logic [`NVRAM_COUNT_W-1:0] ram_lba;
      logic [`NVRAM_RAM_W-1:0]   ram_offset;
   } blk_t;

   logic                       clk;
   logic                       reset;
   nvram_region_t              regions [`NVRAM_CHANNELS];
   logic [`NVRAM_CHANNELS-1:0] img_mounted;
   logic [`NVRAM_SIZE_W-1:0]   img_size;
   logic [`NVRAM_CHANNELS-1:0] load_req;
   logic [`NVRAM_CHANNELS-1:0] save_req;
   logic                       ready;
   logic [`NVRAM_CHANNELS-1:0] sd_rd;
   logic [`NVRAM_CHANNELS-1:0] sd_wr;
   logic [`NVRAM_LBA_W-1:0]    sd_lba;
   logic [`NVRAM_CHANNELS-1:0] sd_ack;
   logic [`NVRAM_COUNT_W-1:0]  ram_lba;
   logic [`NVRAM_RAM_W-1:0]    ram_offset;
   logic                       ram_we;
   logic                       ram_format;
   nvram_report_t              report;
   logic                       done;

   logic [31:0]                stim_state = SEED;
   logic [31:0]                card_state = ~SEED; // Separate stream for ack timing
   logic [`NVRAM_SIZE_W-1:0]   model_size [`NVRAM_CHANNELS];
   logic [`NVRAM_CHANNELS-1:0] model_load;
   logic [`NVRAM_CHANNELS-1:0] model_save;
   blk_t                       seen [$];
   longint                     last_fall = 0; // Time of the latest falling ack
   int                         errors = 0;

   tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

   nvram_sync u_dut (
      .clk         (clk),
      .reset       (reset),
      .regions     (regions),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .load_req    (load_req),
      .save_req    (save_req),
      .ready       (ready),
      .sd_rd       (sd_rd),
      .sd_wr       (sd_wr),
      .sd_lba      (sd_lba),
      .sd_ack      (sd_ack),
      .ram_lba     (ram_lba),
      .ram_offset  (ram_offset),
      .ram_we      (ram_we),
      .ram_format  (ram_format),
      .report      (report),
      .done        (done)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int stim_rand(input int n);
      stim_state = lcg_next(stim_state);
      return int'((stim_state >> 8) % n);
   endfunction

   function automatic int card_rand(input int n);
      card_state = lcg_next(card_state);
      return int'((card_state >> 8) % n);
   endfunction

   task automatic abort(input string why);
      errors++;
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
      if (exp !== act) begin
         errors++;
         $display("Fail %s exp %0h act %0h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   task automatic mount(input int ch, input logic [`NVRAM_SIZE_W-1:0] size);
      img_mounted = `NVRAM_CHANNELS'(1 << ch);
      img_size = size;
      model_size[ch] = size;
      @(negedge clk);
      img_mounted = '0;
   endtask

   task automatic strobe(input logic [3:0] lv, input logic [3:0] sv);
      load_req = lv;
      save_req = sv;
      model_load = model_load | lv;
      model_save = model_save | sv;
      @(negedge clk);
      load_req = '0;
      save_req = '0;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!done && n < TIMEOUT);
      if (!done)
         abort("Timed out waiting for done");
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!ready)
         abort("Timed out waiting for ready");
   endtask

   task automatic wait_activity(output logic [3:0] active);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while ((sd_rd | sd_wr) == '0 && n < TIMEOUT);
      active = sd_rd | sd_wr;
      if (active == '0)
         abort("No SD request appeared after the strobe");
   endtask

   // Checks the finished job against the region, the pending sets and the size table
   task automatic check_job();
      nvram_report_t rep;
      nvram_region_t r;
      blk_t          exp_blk;
      logic [63:0]   size_blk;
      logic [63:0]   reg_end;
      int            fmt_n;
      int            cnt;
      int            ch;
      rep = report;
      ch = int'(rep.channel);
      r = regions[ch];
      cnt = int'(r.block_count);
      if (rep.op == OP_SAVE) begin
         check("save pending", 1, model_save[ch]);
         model_save[ch] = 1'b0;
      end else begin
         check("load pending", 1, model_load[ch]);
         check("save done before load", 0, model_save[ch]);
         model_load[ch] = 1'b0;
      end
      size_blk = model_size[ch] >> `NVRAM_BLOCK_SHIFT;
      reg_end = 64'(r.lba_start) + 64'(r.block_count);
      fmt_n = (cnt != 0 && reg_end > size_blk) ? int'(reg_end - size_blk) : 0;
      check("block count", fmt_n + cnt, seen.size());
      for (int i = 0; i < fmt_n + cnt; i++) begin
         exp_blk.channel = rep.channel;
         exp_blk.fmt = (i < fmt_n);
         exp_blk.rd = !exp_blk.fmt && rep.op == OP_LOAD;
         exp_blk.wr = !exp_blk.rd;
         exp_blk.we = exp_blk.rd; // Load writes RAM
         exp_blk.ram_lba = exp_blk.fmt ? 13'(i) : 13'(i - fmt_n);
         exp_blk.lba = exp_blk.fmt ? 32'(size_blk) + 32'(i) : r.lba_start + 32'(i - fmt_n);
         exp_blk.ram_offset = r.ram_offset;
         check("sd block", exp_blk, seen[i]);
      end
      // Done comes 3 cycles after the last falling ack
      if (fmt_n + cnt > 0)
         check("done latency", 300, $time - last_fall);
      model_size[ch] = model_size[ch] + (64'(fmt_n) << `NVRAM_BLOCK_SHIFT);
      check("report.fmt_blocks", fmt_n, rep.fmt_blocks);
      check("report.xfer_blocks", cnt, rep.xfer_blocks);
      check("report.final_size", model_size[ch], rep.final_size);
      seen.delete();
   endtask

   task automatic run_one(input int ch, input nvram_op_t op);
      logic [3:0] bit_v;
      bit_v = 4'(1 << ch);
      if (op == OP_SAVE)
         strobe('0, bit_v);
      else
         strobe(bit_v, '0);
      wait_done();
      check("report.channel", ch, report.channel);
      check("report.op", op, report.op);
      check_job();
   endtask

   // SD card: ack after a random delay, one block per ack pulse
   initial begin : card
      logic [3:0] req;
      blk_t       blk;
      int         ch;
      sd_ack = '0;
      forever begin
         @(negedge clk);
         req = sd_rd | sd_wr;
         if (req != '0) begin
            ch = 0;
            for (int i = 0; i < `NVRAM_CHANNELS; i++)
               if (req[i])
                  ch = i;
            repeat (1 + card_rand(6)) @(negedge clk);
            blk.channel = 2'(ch);
            blk.lba = sd_lba;
            blk.rd = sd_rd[ch];
            blk.wr = sd_wr[ch];
            blk.fmt = ram_format;
            blk.we = ram_we;
            blk.ram_lba = ram_lba;
            blk.ram_offset = ram_offset;
            seen.push_back(blk);
            sd_ack[ch] = 1'b1;
            repeat (1 + card_rand(3)) @(negedge clk);
            sd_ack[ch] = 1'b0;
            last_fall = $time;
         end
      end
   end

   initial begin : main
      logic [3:0]  lv;
      logic [3:0]  sv;
      logic [3:0]  active;
      logic [63:0] size;
      reset = 1'b1;
      img_mounted = '0;
      img_size = '0;
      load_req = '0;
      save_req = '0;
      model_load = '0;
      model_save = '0;
      for (int i = 0; i < `NVRAM_CHANNELS; i++) begin
         regions[i] = '0;
         model_size[i] = '0;
      end
      repeat (4) @(negedge clk);
      reset = 1'b0;

      check("sd_rd", 0, sd_rd);
      check("sd_wr", 0, sd_wr);
      check("ram_format", 0, ram_format);
      check("done", 0, done);
      check("ready", 1, ready);

      // Image covers the region
      regions[0].lba_start = 32'(stim_rand(32));
      regions[0].block_count = 13'(1 + stim_rand(6));
      regions[0].ram_offset = 25'(stim_rand(1 << 20));
      size = 64'((int'(regions[0].lba_start) + int'(regions[0].block_count) +
                  stim_rand(8)) * 512 + stim_rand(512));
      mount(0, size);
      run_one(0, OP_SAVE);
      check("report.fmt_blocks", 0, report.fmt_blocks);
      check("report.final_size", size, report.final_size);
      run_one(0, OP_LOAD);

      // Region reaching past the image end
      size = 64'((8 + stim_rand(8)) * 512 + stim_rand(512));
      mount(2, size);
      regions[2].lba_start = 32'(int'(size >> `NVRAM_BLOCK_SHIFT) - 2 + stim_rand(4));
      regions[2].block_count = 13'(3 + stim_rand(4));
      regions[2].ram_offset = 25'(stim_rand(1 << 20));
      run_one(2, OP_SAVE);
      check("format used", 1, report.fmt_blocks != 0);
      run_one(2, OP_LOAD);
      check("report.fmt_blocks", 0, report.fmt_blocks);

      regions[3].lba_start = 32'(stim_rand(64));
      regions[3].block_count = '0;
      run_one(3, OP_LOAD);

      // Random mix over all channels
      for (int i = 0; i < `NVRAM_CHANNELS; i++) begin
         regions[i].lba_start = 32'(stim_rand(12));
         regions[i].block_count = 13'(1 + stim_rand(4));
         regions[i].ram_offset = 25'(stim_rand(1 << 24));
         mount(i, 64'(stim_rand(14) * 512 + stim_rand(512)));
      end
      for (int round = 0; round < 8; round++) begin
         lv = 4'(stim_rand(16));
         sv = 4'(stim_rand(16));
         if ((lv | sv) == '0)
            sv = 4'b0001;
         strobe(lv, sv);
         wait_activity(active);
         // Repeats only on channels still queued
         strobe(lv & ~active & 4'(stim_rand(16)), sv & ~active & 4'(stim_rand(16)));
         while ((model_load | model_save) != '0) begin
            wait_done();
            check_job();
         end
         wait_ready();
      end

      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== nvram_sync.f ====
+incdir+logic
logic/nvram_pkg.sv
logic/nvram_request_arbiter.sv
logic/nvram_transfer_fsm.sv
logic/nvram_completion.sv
logic/nvram_sync.sv
tests/tb_clock.sv
tests/nvram_sync_tb.sv
